//--- hdl/sdram_macros.svh
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// ----------------------------------------
// Address split of the device
// ----------------------------------------
`define SDRAM_ADDR_W 26
`define ROW_W 12
`define BANK_W 2
`define COL_W 12
`define PAGE_W 14
`define BUS_ADDR_W 13
`define MASK_W 4

// A10 set selects all banks
`define PRCH_ALL_ADDR 13'h0400

// ----------------------------------------
// Command spacing
// ----------------------------------------
`define CNT_LOAD_REFRESH 4'd3
`define CNT_LOAD_ACTV 4'd12
`define CNT_LOAD_IDLE 4'd14
`define CNT_LOAD_RW 4'd11

`define ACTV_WAIT 3 // Done when top bit set

`endif

//--- hdl/sdram_pkg.sv
`default_nettype none

`include "sdram_macros.svh"

package sdram_pkg;

  // Device command pins {RAS, CAS, WE}
  typedef enum logic [2:0] {
    MRST = 3'd0,
    ARSR = 3'd1,
    PRCH = 3'd2,
    ACTV = 3'd3,
    WRTE = 3'd4,
    READ = 3'd5,
    BTRM = 3'd6,
    NOOP = 3'd7
  } sdram_cmd_e;

  typedef union packed {
    struct packed {
      logic [`PAGE_W-1:0] tag; // Row and bank together
      logic [`COL_W-1:0]  col;
    } page;
    struct packed {
      logic [`ROW_W-1:0]  row;
      logic [`BANK_W-1:0] bank;
      logic [`COL_W-1:0]  col;
    } field;
  } sdram_addr_u;

endpackage

`default_nettype wire

//--- hdl/page_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

interface page_req_if;
  import sdram_pkg::*;

  logic               rand_req;
  logic               rand_we;
  sdram_addr_u        rand_addr;
  logic [`MASK_W-1:0] rand_mask;
  logic               bulk_req;
  logic               bulk_we;
  sdram_addr_u        bulk_addr;
  logic [`MASK_W-1:0] bulk_mask;
  logic               rand_hit;
  logic               bulk_hit;
  logic               any_hit;

  modport src (output rand_req, rand_we, rand_addr, rand_mask,
               output bulk_req, bulk_we, bulk_addr, bulk_mask,
               output rand_hit, bulk_hit, any_hit);
  modport dst (input rand_req, rand_we, rand_addr, rand_mask,
               input bulk_req, bulk_we, bulk_addr, bulk_mask,
               input rand_hit, bulk_hit, any_hit);

endinterface

`default_nettype wire

//--- hdl/bank_state_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

interface bank_state_if;
  import sdram_pkg::*;

  logic               issued;     // Decision, one cycle
  sdram_cmd_e         issued_cmd; // Command on the pins
  logic [`PAGE_W-1:0] page_current;
  logic               second_stroke;
  logic               page_active;
  logic               state_is_write;
  logic               state_is_readwrite;
  logic               refresh_due;
  logic               actv_done;
  logic               change_ok;

  modport issue (output issued, issued_cmd, page_current,
                 input second_stroke, page_active, state_is_write,
                 input state_is_readwrite, refresh_due, actv_done, change_ok);
  modport track (input issued, issued_cmd,
                 output second_stroke, page_active, state_is_write,
                 output state_is_readwrite, refresh_due, actv_done, change_ok);
  modport hit (input page_current, page_active, refresh_due);

endinterface

`default_nettype wire

//--- hdl/page_hit_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

module page_hit_detect (
  input wire                     INPUT_CLK,
  input wire                     RST,
  input wire                     rand_request,
  input wire                     rand_we,
  input wire [`SDRAM_ADDR_W-1:0] rand_address,
  input wire [`MASK_W-1:0]       rand_mask,
  input wire                     bulk_request,
  input wire                     bulk_we,
  input wire [`SDRAM_ADDR_W-1:0] bulk_address,
  input wire [`MASK_W-1:0]       bulk_mask,
  page_req_if.src                req,
  bank_state_if.hit              bstate
);
  import sdram_pkg::*;

  sdram_addr_u rand_live;
  sdram_addr_u bulk_live;
  logic        page_open;
  logic        rand_hit_w;
  logic        bulk_hit_w;

  assign rand_live = rand_address;
  assign bulk_live = bulk_address;

  // No hits while a refresh is owed
  assign page_open = bstate.page_active && !bstate.refresh_due;

  assign bulk_hit_w = bulk_request && page_open &&
                      (bulk_live.page.tag == bstate.page_current);

  // Random yields to any bulk request
  assign rand_hit_w = rand_request && !bulk_request && page_open &&
                      (rand_live.page.tag == bstate.page_current);

  // ----------------------------------------
  // Sampling stage
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      req.rand_req <= 1'b0;
      req.bulk_req <= 1'b0;
      req.rand_hit <= 1'b0;
      req.bulk_hit <= 1'b0;
      req.any_hit  <= 1'b0;
    end
    else
    begin
      req.rand_req <= rand_request;
      req.bulk_req <= bulk_request;
      req.rand_hit <= rand_hit_w;
      req.bulk_hit <= bulk_hit_w;
      req.any_hit  <= rand_hit_w || bulk_hit_w;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    req.rand_we   <= rand_we;
    req.rand_addr <= rand_address;
    req.rand_mask <= rand_mask;
    req.bulk_we   <= bulk_we;
    req.bulk_addr <= bulk_address;
    req.bulk_mask <= bulk_mask;
  end

  a_no_hit_on_refresh : assert property (@(posedge INPUT_CLK) disable iff (!RST)
    $past(bstate.refresh_due) |-> !(req.rand_hit || req.bulk_hit));

endmodule

`default_nettype wire

//--- hdl/bank_state_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

module bank_state_tracker (
  input wire          INPUT_CLK,
  input wire          RST,
  input wire          refresh_strobe,
  bank_state_if.track bstate
);
  import sdram_pkg::*;

  logic                  refresh_ack;
  logic                  do_extra_pass; // Second lap after ARSR
  logic [3:0]            counter;
  logic [`ACTV_WAIT-1:0] actv_wait;
  logic                  norm_window;
  logic                  dlay_window;
  logic                  prch_delay;
  logic                  change_ok_w;

  assign bstate.actv_done = actv_wait[`ACTV_WAIT-1];

  // ----------------------------------------
  // Spacing windows
  // ----------------------------------------
  assign norm_window = (counter == 4'd13) || (counter == 4'd14);
  assign dlay_window = (counter == 4'd14) || (counter == 4'd15);

  // Write recovery before a precharge
  assign prch_delay = bstate.page_active && bstate.state_is_write;

  assign change_ok_w = bstate.second_stroke && !do_extra_pass &&
                       (prch_delay ? dlay_window : norm_window);

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      bstate.second_stroke      <= 1'b1;
      bstate.page_active        <= 1'b0;
      bstate.state_is_write     <= 1'b0;
      bstate.state_is_readwrite <= 1'b0;
      bstate.refresh_due        <= 1'b0;
      bstate.change_ok          <= 1'b0;
      refresh_ack               <= 1'b0;
      do_extra_pass             <= 1'b0;
      counter                   <= `CNT_LOAD_IDLE;
      actv_wait                 <= '1;
    end
    else
    begin
      bstate.second_stroke <= !bstate.issued;
      bstate.refresh_due   <= refresh_ack ^ refresh_strobe;

      if (!bstate.second_stroke && (bstate.issued_cmd == ACTV))
        actv_wait <= '0;
      else if (!bstate.actv_done)
        actv_wait <= actv_wait + 1'b1;

      if (!bstate.second_stroke)
      begin
        if (bstate.issued_cmd == ACTV)
          bstate.page_active <= 1'b1;
        if (bstate.issued_cmd == PRCH)
          bstate.page_active <= 1'b0;

        if (bstate.issued_cmd == WRTE)
          bstate.state_is_write <= 1'b1;
        else if (bstate.issued_cmd != NOOP)
          bstate.state_is_write <= 1'b0;

        bstate.state_is_readwrite <= (bstate.issued_cmd == READ) ||
                                     (bstate.issued_cmd == WRTE);

        if (bstate.issued_cmd == ARSR)
        begin
          refresh_ack   <= refresh_strobe;
          do_extra_pass <= 1'b1;
        end

        case (bstate.issued_cmd)
          ARSR:    counter <= `CNT_LOAD_REFRESH;
          ACTV:    counter <= `CNT_LOAD_ACTV;
          NOOP:    counter <= `CNT_LOAD_IDLE;
          default: counter <= `CNT_LOAD_RW;
        endcase
      end
      else
      begin
        counter <= counter + {3'b000, !bstate.change_ok}; // Parks once open
        if (counter == 4'd0)
          do_extra_pass <= 1'b0;
      end

      if (bstate.issued)
        bstate.change_ok <= 1'b0;
      else
        bstate.change_ok <= change_ok_w;
    end
  end

  a_page_open_by_actv : assert property (@(posedge INPUT_CLK) disable iff (!RST)
    $rose(bstate.page_active) |-> $past(bstate.issued_cmd == ACTV));

endmodule

`default_nettype wire

//--- hdl/command_issuer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

module command_issuer (
  input wire                       INPUT_CLK,
  input wire                       RST,
  page_req_if.dst                  req,
  bank_state_if.issue              bstate,
  output sdram_pkg::sdram_cmd_e    cmd,
  output logic [`BUS_ADDR_W-1:0]   bus_address,
  output logic [`BANK_W-1:0]       bank,
  output logic [`MASK_W-1:0]       we_mask,
  output logic                     rand_grant,
  output logic                     bulk_grant
);
  import sdram_pkg::*;

  sdram_addr_u             sel_addr;
  sdram_cmd_e              cmd_rw;
  sdram_cmd_e              cmd_non_rw;
  sdram_cmd_e              cmd_next;
  logic                    write_match;
  logic                    issue_on_page;
  logic                    issue_override;
  logic                    issue_com;
  logic                    prch_now;
  logic [`BUS_ADDR_W-1:0]  addr_next;
  logic [`MASK_W-1:0]      mask_sel;

  // Bulk first
  assign sel_addr    = req.bulk_req ? req.bulk_addr : req.rand_addr;
  assign mask_sel    = req.bulk_req ? req.bulk_mask : req.rand_mask;
  assign write_match = req.bulk_req ? req.bulk_we : (req.rand_req && req.rand_we);

  // ----------------------------------------
  // Issue decision
  // ----------------------------------------
  assign issue_on_page = bstate.second_stroke && bstate.state_is_readwrite &&
                         (bstate.state_is_write == write_match);

  assign issue_override = bstate.second_stroke && bstate.change_ok &&
                          (req.rand_req || req.bulk_req || bstate.refresh_due);

  assign issue_com = (req.any_hit && issue_on_page) || issue_override;

  assign bstate.issued     = issue_com;
  assign bstate.issued_cmd = cmd;

  always_comb
  begin
    case ({bstate.page_active, bstate.refresh_due, bstate.actv_done})
      3'b101, 3'b111: cmd_non_rw = PRCH;
      3'b010, 3'b011: cmd_non_rw = ARSR;
      3'b000, 3'b001: cmd_non_rw = ACTV;
      default:        cmd_non_rw = NOOP; // Activate wait not over
    endcase
  end

  assign cmd_rw   = write_match ? WRTE : READ;
  assign cmd_next = req.any_hit ? cmd_rw : cmd_non_rw;

  // ----------------------------------------
  // Address mux
  // ----------------------------------------
  assign prch_now = bstate.page_active && !req.any_hit;

  assign addr_next = prch_now    ? `PRCH_ALL_ADDR :
                     req.any_hit ? {sel_addr.field.col, 1'b0} :
                     {sel_addr.field.row[11:10], 1'b0, sel_addr.field.row[9:0]};

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cmd                 <= NOOP;
      bus_address         <= `PRCH_ALL_ADDR;
      bank                <= '0;
      we_mask             <= '0;
      rand_grant          <= 1'b0;
      bulk_grant          <= 1'b0;
      bstate.page_current <= '0;
    end
    else
    begin
      cmd        <= issue_com ? cmd_next : NOOP;
      rand_grant <= issue_com && req.rand_hit;
      bulk_grant <= issue_com && req.bulk_hit;

      if (issue_com)
      begin
        bus_address <= addr_next;
        we_mask     <= mask_sel;
        if (!prch_now)
        begin
          bstate.page_current <= sel_addr.page.tag; // Unchanged on a hit
          bank                <= sel_addr.field.bank;
        end
      end
    end
  end

  a_grant_onehot : assert property (@(posedge INPUT_CLK) disable iff (!RST)
    !(rand_grant && bulk_grant));

endmodule

`default_nettype wire

//--- hdl/sdram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_ctrl (
  input wire                     INPUT_CLK,
  input wire                     RST,
  input wire                     refresh_strobe,
  // Random port
  input wire [`SDRAM_ADDR_W-1:0] rand_address,
  input wire                     rand_we,
  input wire                     rand_request,
  input wire [`MASK_W-1:0]       rand_mask,
  output logic                   rand_grant,
  // Bulk port
  input wire [`SDRAM_ADDR_W-1:0] bulk_address,
  input wire                     bulk_we,
  input wire                     bulk_request,
  input wire [`MASK_W-1:0]       bulk_mask,
  output logic                   bulk_grant,
  // Device side
  output sdram_pkg::sdram_cmd_e  cmd,
  output logic [`BUS_ADDR_W-1:0] bus_address,
  output logic [`BANK_W-1:0]     bank,
  output logic [`MASK_W-1:0]     we_mask
);

  page_req_if   i_page_req ();
  bank_state_if i_bank_state ();

  page_hit_detect i_page_hit_detect (
    .INPUT_CLK    (INPUT_CLK),
    .RST          (RST),
    .rand_request (rand_request),
    .rand_we      (rand_we),
    .rand_address (rand_address),
    .rand_mask    (rand_mask),
    .bulk_request (bulk_request),
    .bulk_we      (bulk_we),
    .bulk_address (bulk_address),
    .bulk_mask    (bulk_mask),
    .req          (i_page_req.src),
    .bstate       (i_bank_state.hit)
  );

  bank_state_tracker i_bank_state_tracker (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .bstate         (i_bank_state.track)
  );

  command_issuer i_command_issuer (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .req         (i_page_req.dst),
    .bstate      (i_bank_state.issue),
    .cmd         (cmd),
    .bus_address (bus_address),
    .bank        (bank),
    .we_mask     (we_mask),
    .rand_grant  (rand_grant),
    .bulk_grant  (bulk_grant)
  );

endmodule

`default_nettype wire

//--- tests/sdram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_ctrl_tb;
  import sdram_pkg::*;

  localparam int WAIT_LIMIT = 200; // Cycles per wait
  localparam logic [`BUS_ADDR_W-1:0] EXP_PRCH_ADDR = 13'h0400;

  logic                     INPUT_CLK;
  logic                     RST;
  logic                     refresh_strobe;
  logic [`SDRAM_ADDR_W-1:0] rand_address;
  logic                     rand_we;
  logic                     rand_request;
  logic [`MASK_W-1:0]       rand_mask;
  logic                     rand_grant;
  logic [`SDRAM_ADDR_W-1:0] bulk_address;
  logic                     bulk_we;
  logic                     bulk_request;
  logic [`MASK_W-1:0]       bulk_mask;
  logic                     bulk_grant;
  sdram_cmd_e               cmd;
  logic [`BUS_ADDR_W-1:0]   bus_address;
  logic [`BANK_W-1:0]       bank;
  logic [`MASK_W-1:0]       we_mask;

  logic [31:0]              lcg_state;
  logic [`PAGE_W-1:0]       open_page; // Row and bank left open
  sdram_cmd_e               prev_cmd = NOOP;

  sdram_ctrl i_sdram_ctrl (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_address   (rand_address),
    .rand_we        (rand_we),
    .rand_request   (rand_request),
    .rand_mask      (rand_mask),
    .rand_grant     (rand_grant),
    .bulk_address   (bulk_address),
    .bulk_we        (bulk_we),
    .bulk_request   (bulk_request),
    .bulk_mask      (bulk_mask),
    .bulk_grant     (bulk_grant),
    .cmd            (cmd),
    .bus_address    (bus_address),
    .bank           (bank),
    .we_mask        (we_mask)
  );

  always #20 INPUT_CLK = !INPUT_CLK;

  // ----------------------------------------
  // Reporting and stimulus helpers
  // ----------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("mismatch at %0t ns: %s", $time, what));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`SDRAM_ADDR_W-1:0] random_address();
    logic [31:0] rnd;
    rnd = lcg_next();
    return rnd[31:6]; // Upper bits mix best
  endfunction

  function automatic logic [`SDRAM_ADDR_W-1:0] page_address(input logic [`PAGE_W-1:0] page);
    logic [31:0] rnd;
    rnd = lcg_next();
    return {page, rnd[31:20]};
  endfunction

  function automatic logic [`MASK_W-1:0] random_mask();
    logic [31:0] rnd;
    rnd = lcg_next();
    return rnd[31:28];
  endfunction

  // Device address for ACTV, A10 kept clear
  function automatic logic [`BUS_ADDR_W-1:0] row_bus(input logic [`SDRAM_ADDR_W-1:0] addr);
    logic [11:0] row;
    row = addr[25:14];
    return {row[11:10], 1'b0, row[9:0]};
  endfunction

  function automatic logic [`BUS_ADDR_W-1:0] col_bus(input logic [`SDRAM_ADDR_W-1:0] addr);
    return {addr[11:0], 1'b0};
  endfunction

  function automatic logic [`BANK_W-1:0] bank_of(input logic [`SDRAM_ADDR_W-1:0] addr);
    return addr[13:12];
  endfunction

  task automatic wait_command(input string what);
    int n;
    n = 0;
    @(negedge INPUT_CLK);
    while ((cmd == NOOP) && (n < WAIT_LIMIT))
    begin
      n++;
      @(negedge INPUT_CLK);
    end
    if (cmd == NOOP)
      abort_run($sformatf("timeout waiting for %s", what));
  endtask

  task automatic expect_command(input sdram_cmd_e exp_cmd, input logic chk_addr,
                                input logic [`BUS_ADDR_W-1:0] exp_addr, input logic chk_bank,
                                input logic [`BANK_W-1:0] exp_bank, input logic exp_rgrant,
                                input logic exp_bgrant);
    wait_command($sformatf("command %0d", exp_cmd));
    assert (cmd == exp_cmd)
      else report_mismatch($sformatf("cmd %0d, expected %0d", cmd, exp_cmd));
    assert (!chk_addr || (bus_address == exp_addr))
      else report_mismatch($sformatf("bus_address %h, expected %h", bus_address, exp_addr));
    assert (!chk_bank || (bank == exp_bank))
      else report_mismatch($sformatf("bank %0d, expected %0d", bank, exp_bank));
    assert ((rand_grant == exp_rgrant) && (bulk_grant == exp_bgrant))
      else report_mismatch($sformatf("grants %b%b, expected %b%b", rand_grant, bulk_grant,
                                     exp_rgrant, exp_bgrant));
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic check_reset();
    assert ((cmd == NOOP) && (bus_address == EXP_PRCH_ADDR) && (bank == '0))
      else report_mismatch("command outputs not at reset values");
    assert (!rand_grant && !bulk_grant && (we_mask == '0))
      else report_mismatch("grants or we_mask not clear in reset");
  endtask

  task automatic test_closed_read();
    logic [`SDRAM_ADDR_W-1:0] addr;
    addr = random_address();
    rand_address = addr;
    rand_we = 1'b0;
    rand_mask = random_mask();
    rand_request = 1'b1;
    expect_command(ACTV, 1'b1, row_bus(addr), 1'b1, bank_of(addr), 1'b0, 1'b0);
    expect_command(READ, 1'b1, col_bus(addr), 1'b1, bank_of(addr), 1'b1, 1'b0);
    rand_request = 1'b0;
    open_page = addr[25:12];
  endtask

  task automatic test_bulk_write();
    logic [`SDRAM_ADDR_W-1:0] addr;
    logic [`MASK_W-1:0]       mask;
    addr = page_address(open_page);
    mask = random_mask();
    bulk_address = addr;
    bulk_we = 1'b1;
    bulk_mask = mask;
    bulk_request = 1'b1;
    expect_command(WRTE, 1'b1, col_bus(addr), 1'b1, bank_of(addr), 1'b0, 1'b1);
    assert (we_mask == mask)
      else report_mismatch($sformatf("we_mask %h, expected %h", we_mask, mask));
    bulk_request = 1'b0;
  endtask

  task automatic test_both_ports();
    logic [`SDRAM_ADDR_W-1:0] baddr;
    logic [`SDRAM_ADDR_W-1:0] raddr;
    logic [`MASK_W-1:0]       mask;
    baddr = page_address(open_page);
    raddr = page_address(open_page);
    mask = random_mask();
    bulk_address = baddr;
    bulk_we = 1'b1;
    bulk_mask = mask;
    rand_address = raddr;
    rand_we = 1'b0;
    bulk_request = 1'b1;
    rand_request = 1'b1;
    expect_command(WRTE, 1'b1, col_bus(baddr), 1'b1, bank_of(baddr), 1'b0, 1'b1);
    assert (we_mask == mask)
      else report_mismatch($sformatf("we_mask %h, expected %h", we_mask, mask));
    bulk_request = 1'b0;
    expect_command(READ, 1'b1, col_bus(raddr), 1'b1, bank_of(raddr), 1'b1, 1'b0);
    rand_request = 1'b0;
  endtask

  task automatic test_page_miss();
    logic [`SDRAM_ADDR_W-1:0] addr;
    logic [`MASK_W-1:0]       mask;
    addr = random_address();
    if (addr[25:12] == open_page)
      addr[25] = !addr[25]; // Force another row
    mask = random_mask();
    rand_address = addr;
    rand_we = 1'b1;
    rand_mask = mask;
    rand_request = 1'b1;
    expect_command(PRCH, 1'b1, EXP_PRCH_ADDR, 1'b0, '0, 1'b0, 1'b0);
    expect_command(ACTV, 1'b1, row_bus(addr), 1'b1, bank_of(addr), 1'b0, 1'b0);
    expect_command(WRTE, 1'b1, col_bus(addr), 1'b1, bank_of(addr), 1'b1, 1'b0);
    assert (we_mask == mask)
      else report_mismatch($sformatf("we_mask %h, expected %h", we_mask, mask));
    rand_request = 1'b0;
    open_page = addr[25:12];
  endtask

  task automatic test_refresh();
    logic [`SDRAM_ADDR_W-1:0] addr;
    addr = page_address(open_page);
    refresh_strobe = !refresh_strobe;
    expect_command(PRCH, 1'b1, EXP_PRCH_ADDR, 1'b0, '0, 1'b0, 1'b0);
    rand_address = addr; // Raised while the refresh is still owed
    rand_we = 1'b0;
    rand_request = 1'b1;
    expect_command(ARSR, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    expect_command(ACTV, 1'b1, row_bus(addr), 1'b1, bank_of(addr), 1'b0, 1'b0);
    expect_command(READ, 1'b1, col_bus(addr), 1'b1, bank_of(addr), 1'b1, 1'b0);
    rand_request = 1'b0;
  endtask

  // Command spacing and grant exclusivity over the whole run
  always @(negedge INPUT_CLK)
  begin
    if (!RST)
      prev_cmd = NOOP;
    else
    begin
      assert ((prev_cmd == NOOP) || (cmd == NOOP))
        else report_mismatch($sformatf("cmd %0d right after cmd %0d", cmd, prev_cmd));
      assert (!(rand_grant && bulk_grant))
        else report_mismatch("both grants high");
      assert (!(rand_grant || bulk_grant) || (cmd == READ) || (cmd == WRTE))
        else report_mismatch($sformatf("grant with cmd %0d", cmd));
      prev_cmd = cmd;
    end
  end

  initial
  begin
    INPUT_CLK = 1'b0;
    RST = 1'b0;
    refresh_strobe = 1'b0;
    rand_address = '0;
    rand_we = 1'b0;
    rand_request = 1'b0;
    rand_mask = '0;
    bulk_address = '0;
    bulk_we = 1'b0;
    bulk_request = 1'b0;
    bulk_mask = '0;
    lcg_state = 32'h76f0_d4b6;
    open_page = '0;

    repeat (4) @(negedge INPUT_CLK);
    check_reset();
    RST = 1'b1;
    @(negedge INPUT_CLK);

    test_closed_read();
    test_bulk_write();
    test_both_ports();
    test_page_miss();
    test_refresh();

    repeat (4) @(negedge INPUT_CLK); // Let the monitor see the tail
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sdram_ctrl.f
+incdir+hdl
hdl/sdram_pkg.sv
hdl/page_req_if.sv
hdl/bank_state_if.sv
hdl/page_hit_detect.sv
hdl/bank_state_tracker.sv
hdl/command_issuer.sv
hdl/sdram_ctrl.sv
tests/sdram_ctrl_tb.sv

//--- Bender.yml
package:
  name: sdram_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sdram_pkg.sv
      - hdl/page_req_if.sv
      - hdl/bank_state_if.sv
      - hdl/page_hit_detect.sv
      - hdl/bank_state_tracker.sv
      - hdl/command_issuer.sv
      - hdl/sdram_ctrl.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/sdram_ctrl_tb.sv
